// File: Bender.yml
package:
  name: fpu_rnd

sources:
  - files:
      - fpu_rnd_pkg.sv
      - fpu_rnd_ctrl.sv
      - fpu_rnd_align.sv
      - fpu_rnd_round.sv
      - fpu_rnd_pack.sv
      - fpu_rnd_top.sv
  - target: test
    files:
      - tb_fpu_rnd.sv

// File: files.f
fpu_rnd_pkg.sv
fpu_rnd_ctrl.sv
fpu_rnd_align.sv
fpu_rnd_round.sv
fpu_rnd_pack.sv
fpu_rnd_top.sv
tb_fpu_rnd.sv

// File: fpu_rnd_align.sv
`timescale 1ns/1ns

module fpu_rnd_align (
  input  logic                   clk,
  input  fpu_rnd_pkg::src_sel_e  src_sel_i,
  input  fpu_rnd_pkg::rnd_mode_e rmode_i,
  input  fpu_rnd_pkg::add_src_t  add_src_i,
  input  fpu_rnd_pkg::mul_src_t  mul_src_i,
  input  logic                   s1_load_i,
  output fpu_rnd_pkg::aligned_t  aligned_o
);
  import fpu_rnd_pkg::*;

  logic        sign;
  logic        inv;
  logic        inf;
  logic        snan;
  logic        qnan;
  logic        anan_sign;
  fract28_t    fract28;
  shamt_t      shr_req;                       // requested by source
  shamt_t      shl;
  shamt_t      shr;                           // effective right shift
  exp10_t      exp_shr;
  exp10_t      exp_shl;
  exp10_t      exp_sh0;
  exp10_t      exp10;
  logic        carry;
  logic [34:0] fract35;
  logic [34:0] fract35_sh;
  logic [34:0] sh_mask;
  logic        sticky_r;
  logic        sticky_l;
  logic        sticky;

  //////////////////////////////////////////////////////////////////////
  // source mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sign      = 1'b0;
    inv       = 1'b0;
    inf       = 1'b0;
    snan      = 1'b0;
    qnan      = 1'b0;
    anan_sign = 1'b0;
    fract28   = '0;
    shr_req   = '0;
    shl       = '0;
    exp_shr   = '0;                          // add never asks for shr
    exp_shl   = '0;
    exp_sh0   = '0;
    case (src_sel_i)
      SRC_ADD: begin
        // exact zero from a subtraction, sign by rounding mode
        sign      = add_src_i.sub_0 ? (rmode_i == RM_TO_INFM) : add_src_i.sign;
        inv       = add_src_i.inv;
        inf       = add_src_i.inf;
        snan      = add_src_i.snan;
        qnan      = add_src_i.qnan;
        anan_sign = add_src_i.anan_sign;
        fract28   = add_src_i.fract28;
        shl       = add_src_i.shl;
        exp_shl   = add_src_i.exp10shl;
        exp_sh0   = add_src_i.exp10sh0;
      end
      SRC_MUL: begin
        sign      = mul_src_i.sign;
        inv       = mul_src_i.inv;
        inf       = mul_src_i.inf;
        snan      = mul_src_i.snan;
        qnan      = mul_src_i.qnan;
        anan_sign = mul_src_i.anan_sign;
        fract28   = mul_src_i.fract28;
        shr_req   = mul_src_i.shr;
        shl       = {4'd0, mul_src_i.shl};
        exp_shr   = mul_src_i.exp10shr;
        exp_shl   = mul_src_i.exp10shl;
        exp_sh0   = mul_src_i.exp10sh0;
      end
      default: ;                             // idle, all zero
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // shift and sticky
  //////////////////////////////////////////////////////////////////////

  assign carry   = fract28[27];               // add/mul overflow bit
  assign fract35 = {7'd0, fract28};
  assign shr     = (|shr_req) ? shr_req : {4'd0, carry};

  assign fract35_sh = (|shr) ? (fract35 >> shr) : (fract35 << shl);

  // right shift: everything below the new round bit
  assign sh_mask  = ~({35{1'b1}} << ({1'b0, shr} + 6'd2));
  assign sticky_r = |(fract35 & sh_mask);

  // left shift pulls r/s into the fraction
  always_comb begin
    case (shl)
      5'd0:    sticky_l = |fract35[1:0];
      5'd1:    sticky_l = fract35[0];
      default: sticky_l = 1'b0;
    endcase
  end

  assign sticky = (|shr) ? sticky_r : sticky_l;

  // exponent for the case that applies
  assign exp10 = (|shr_req) ? exp_shr :
                 (~(|shl))  ? exp_sh0 + {9'd0, carry} :
                              exp_shl;

  // payload register, validity lives in ctrl
  always_ff @(posedge clk) begin
    if (s1_load_i) begin
      aligned_o.sign      <= sign;
      aligned_o.exp10     <= exp10;
      aligned_o.fract32   <= fract35_sh[34:3];
      aligned_o.rs        <= {fract35_sh[2], sticky};
      aligned_o.inv       <= inv;
      aligned_o.inf       <= inf;
      aligned_o.snan      <= snan;
      aligned_o.qnan      <= qnan;
      aligned_o.anan_sign <= anan_sign;
    end
  end

endmodule

// File: fpu_rnd_ctrl.sv
`timescale 1ns/1ns

module fpu_rnd_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  adv_i,        // advance pipe
  input  logic                  flush_i,      // empty pipe
  input  logic                  add_rdy_i,
  input  logic                  mul_rdy_i,
  output fpu_rnd_pkg::src_sel_e src_sel_o,
  output logic                  s1_load_o,
  output logic                  out_load_o,
  output logic                  out_clr_o,
  output logic                  arith_valid_o
);
  import fpu_rnd_pkg::*;

  logic s1_valid;                             // item held in stage 1

  // at most one ready is high, add wins anyway
  always_comb begin
    if (add_rdy_i) begin
      src_sel_o = SRC_ADD;
    end else if (mul_rdy_i) begin
      src_sel_o = SRC_MUL;
    end else begin
      src_sel_o = SRC_NONE;
    end
  end

  // datapath registers just follow the strobes
  assign s1_load_o  = adv_i;
  assign out_load_o = adv_i;
  assign out_clr_o  = flush_i;               // pack gives clr priority

  //////////////////////////////////////////////////////////////////////
  // valid tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid      <= 1'b0;
      arith_valid_o <= 1'b0;
    end else if (flush_i) begin             // flush beats advance
      s1_valid      <= 1'b0;
      arith_valid_o <= 1'b0;
    end else if (adv_i) begin
      s1_valid      <= add_rdy_i | mul_rdy_i; // new item enters
      arith_valid_o <= s1_valid;             // stage 1 moves out
    end
    // adv low holds both, back-pressure
  end

endmodule

// File: fpu_rnd_pack.sv
`timescale 1ns/1ns

module fpu_rnd_pack (
  input  logic                    clk,
  input  logic                    rst,
  input  fpu_rnd_pkg::aligned_t   aligned_i,
  input  fpu_rnd_pkg::rounded_t   rounded_i,
  input  logic                    out_load_i,
  input  logic                    out_clr_i,
  output fpu_rnd_pkg::word_t      result_o,
  output fpu_rnd_pkg::fpu_flags_t flags_o
);
  import fpu_rnd_pkg::*;

  word_t      res_d;
  fpu_flags_t flags_d;
  logic       sign;
  logic       dn;                             // hidden bit missing

  assign sign = aligned_i.sign;
  assign dn   = ~rounded_i.fract24[FRACT_W];

  //////////////////////////////////////////////////////////////////////
  // result select, priority order
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    flags_d     = '0;
    flags_d.snf = aligned_i.inv;
    flags_d.qnf = aligned_i.qnan;
    flags_d.ivf = aligned_i.inv | aligned_i.snan;
    if (aligned_i.snan | aligned_i.qnan) begin
      res_d = {aligned_i.anan_sign, QNAN_BITS}; // nan in, quiet nan out
    end else if (aligned_i.inv) begin
      res_d = {sign, SNAN_BITS};
    end else if ((rounded_i.exp10 > EXP_MAX) | aligned_i.inf) begin
      res_d       = {sign, INF_BITS};
      flags_d.ixf = rounded_i.lost | ~aligned_i.inf;
      flags_d.ovf = ~aligned_i.inf;           // only a real overflow
      flags_d.inf = 1'b1;
    end else if (dn) begin
      // denormal or zero, exponent field forced to 0
      res_d       = {sign, 8'd0, rounded_i.fract24[FRACT_W-1:0]};
      flags_d.ixf = rounded_i.lost;
      flags_d.unf = rounded_i.lost;           // tiny and inexact
      flags_d.zf  = ~(|rounded_i.fract24);
    end else begin
      res_d       = {sign, rounded_i.exp10[7:0], rounded_i.fract24[FRACT_W-1:0]};
      flags_d.ixf = rounded_i.lost;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result_o <= '0;
      flags_o  <= '0;
    end else if (out_clr_i) begin            // flush wins over load
      result_o <= '0;
      flags_o  <= '0;
    end else if (out_load_i) begin
      result_o <= res_d;
      flags_o  <= flags_d;
    end
  end

endmodule

// File: fpu_rnd_patterns.txt
# grp src(1 add,2 mul) rm sign sub0 shr shl exp_shr exp_shl exp_sh0 fract28
# fl5{inv,inf,snan,qnan,nan_sign} result flags{ovf,unf,snf,qnf,zf,ixf,ivf,inf}
1 1 0 0 0 00 00 000 000 07f 6000005 00 3fc00001 04
1 1 0 0 0 00 00 000 000 07f 6000004 00 3fc00000 04
1 1 0 0 0 00 00 000 000 07f 600000c 00 3fc00002 04
1 1 0 0 0 00 00 000 000 07f 7fffffd 00 40000000 04
1 1 0 0 0 00 00 000 000 07f c000008 00 40400000 04
1 1 0 0 0 00 02 000 07d 000 1000000 00 3e800000 00
2 2 0 0 0 00 00 000 000 081 491a2b2 00 40923456 04
2 2 1 0 0 00 00 000 000 081 491a2b2 00 40923456 04
2 2 2 0 0 00 00 000 000 081 491a2b2 00 40923457 04
2 2 3 0 0 00 00 000 000 081 491a2b2 00 40923456 04
2 2 0 1 0 00 00 000 000 081 491a2b2 00 c0923456 04
2 2 1 1 0 00 00 000 000 081 491a2b2 00 c0923456 04
2 2 2 1 0 00 00 000 000 081 491a2b2 00 c0923456 04
2 2 3 1 0 00 00 000 000 081 491a2b2 00 c0923457 04
3 2 0 0 0 03 00 000 000 000 4000028 00 00100001 44
3 2 0 0 0 1f 00 000 000 000 4000000 00 00000000 4c
3 2 2 0 0 1f 00 000 000 000 4000000 00 00000001 44
3 2 3 1 0 1f 00 000 000 000 4000000 00 80000001 44
3 2 0 0 0 02 00 000 000 000 4000000 00 00200000 00
4 1 0 0 0 00 00 000 000 0ff 0000000 03 ffc00000 10
4 2 0 0 0 00 00 000 000 081 4000000 04 7fc00000 02
4 1 0 0 0 00 00 000 000 07f 4000000 10 7fbfffff 22
4 2 0 1 0 00 00 000 000 0ff 0000000 08 ff800000 01
4 1 0 0 0 00 00 000 000 0ff 4000000 00 7f800000 85
4 1 0 0 0 00 00 000 000 0fe 7fffffd 00 7f800000 85
4 1 0 0 1 00 00 000 000 000 0000000 00 00000000 08
4 1 3 0 1 00 00 000 000 000 0000000 00 80000000 08
4 1 1 1 1 00 00 000 000 000 0000000 00 00000000 08
5 1 0 0 0 00 00 000 000 07f 6000005 00 3fc00001 04
5 2 2 0 0 00 00 000 000 081 491a2b2 00 40923457 04
5 2 0 0 0 03 00 000 000 000 4000028 00 00100001 44
5 1 0 0 0 00 00 000 000 0ff 0000000 03 ffc00000 10
6 1 0 0 0 00 00 000 000 07f 6000005 00 00000000 00

// File: fpu_rnd_pkg.sv
package fpu_rnd_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and vector types
  //////////////////////////////////////////////////////////////////////

  localparam int FRACT_W = 23;               // stored fraction bits

  typedef logic [31:0] word_t;               // ieee-754 single word
  typedef logic [9:0]  exp10_t;              // biased exp, guard range
  typedef logic [27:0] fract28_t;            // {carry, hidden, 23b, r, s}
  typedef logic [31:0] fract32_t;            // aligned fraction
  typedef logic [4:0]  shamt_t;              // shift amount

  // largest finite biased exponent
  localparam exp10_t EXP_MAX = 10'd254;

  // magnitude patterns, sign is prepended at pack
  localparam logic [30:0] INF_BITS  = 31'h7f800000;
  localparam logic [30:0] QNAN_BITS = 31'h7fc00000;
  localparam logic [30:0] SNAN_BITS = 31'h7fbfffff;

  //////////////////////////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    RM_NEAREST = 2'b00,                      // nearest, ties to even
    RM_TO_ZERO = 2'b01,
    RM_TO_INFP = 2'b10,
    RM_TO_INFM = 2'b11
  } rnd_mode_e;

  typedef enum logic [1:0] {
    SRC_NONE = 2'b00,
    SRC_ADD  = 2'b01,
    SRC_MUL  = 2'b10
  } src_sel_e;

  //////////////////////////////////////////////////////////////////////
  // source and stage structs
  //////////////////////////////////////////////////////////////////////

  // from the add/sub unit
  typedef struct packed {
    logic     sign;
    logic     sub_0;                         // subtraction gave exact zero
    shamt_t   shl;                           // left shift for align
    exp10_t   exp10shl;                      // exp if left shifted
    exp10_t   exp10sh0;                      // exp if not shifted
    fract28_t fract28;
    logic     inv;                           // invalid operation
    logic     inf;                           // infinity operand
    logic     snan;
    logic     qnan;
    logic     anan_sign;                     // sign for nan output
  } add_src_t;

  // from the multiplier
  typedef struct packed {
    logic     sign;
    shamt_t   shr;                           // right shift for align
    exp10_t   exp10shr;                      // exp if right shifted
    logic     shl;                           // one bit left shift request
    exp10_t   exp10shl;
    exp10_t   exp10sh0;
    fract28_t fract28;
    logic     inv;
    logic     inf;
    logic     snan;
    logic     qnan;
    logic     anan_sign;
  } mul_src_t;

  // stage 1 register
  typedef struct packed {
    logic       sign;
    exp10_t     exp10;
    fract32_t   fract32;
    logic [1:0] rs;                          // {round, sticky}
    logic       inv;
    logic       inf;
    logic       snan;
    logic       qnan;
    logic       anan_sign;
  } aligned_t;

  // rounder output
  typedef struct packed {
    exp10_t      exp10;                      // after carry renorm
    logic [23:0] fract24;                    // hidden bit + fraction
    logic        lost;                       // round or sticky set
  } rounded_t;

  typedef struct packed {
    logic ovf;
    logic unf;
    logic snf;
    logic qnf;
    logic zf;
    logic ixf;
    logic ivf;
    logic inf;
  } fpu_flags_t;

endpackage

// File: fpu_rnd_round.sv
`timescale 1ns/1ns

module fpu_rnd_round (
  input  fpu_rnd_pkg::aligned_t  aligned_i,
  input  fpu_rnd_pkg::rnd_mode_e rmode_i,
  output fpu_rnd_pkg::rounded_t  rounded_o
);
  import fpu_rnd_pkg::*;

  logic     g;                                // lsb of kept fraction
  logic     r;
  logic     s;
  logic     lost;
  logic     rnd_up;
  fract32_t fract32_rnd;
  logic     renorm;                           // carry out of hidden bit

  assign g    = aligned_i.fract32[0];
  assign r    = aligned_i.rs[1];
  assign s    = aligned_i.rs[0];
  assign lost = r | s;

  //////////////////////////////////////////////////////////////////////
  // increment decision
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (rmode_i)
      RM_NEAREST: rnd_up = r & (s | g);      // above half, or tie to odd
      RM_TO_ZERO: rnd_up = 1'b0;             // plain truncate
      RM_TO_INFP: rnd_up = ~aligned_i.sign & lost;
      RM_TO_INFM: rnd_up = aligned_i.sign & lost;
      default:    rnd_up = 1'b0;
    endcase
  end

  assign fract32_rnd = aligned_i.fract32 + {31'd0, rnd_up};

  // all ones plus one spills into bit 24
  assign renorm = fract32_rnd[24];

  assign rounded_o.exp10   = aligned_i.exp10 + {9'd0, renorm};
  assign rounded_o.fract24 = renorm ? fract32_rnd[24:1] : fract32_rnd[23:0];
  assign rounded_o.lost    = lost;

endmodule

// File: fpu_rnd_top.sv
`timescale 1ns/1ns

module fpu_rnd_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    adv_i,
  input  logic                    flush_i,
  input  fpu_rnd_pkg::rnd_mode_e  rmode_i,
  input  logic                    add_rdy_i,
  input  logic                    mul_rdy_i,
  input  fpu_rnd_pkg::add_src_t   add_src_i,
  input  fpu_rnd_pkg::mul_src_t   mul_src_i,
  output fpu_rnd_pkg::word_t      result_o,
  output logic                    arith_valid_o,
  output fpu_rnd_pkg::fpu_flags_t flags_o
);
  import fpu_rnd_pkg::*;

  src_sel_e src_sel;
  logic     s1_load;
  logic     out_load;
  logic     out_clr;
  aligned_t aligned;                          // stage 1 register
  rounded_t rounded;                          // comb, stage 2

  // strobes and valid bits
  fpu_rnd_ctrl fpu_rnd_ctrl_i (
    .clk           (clk),
    .rst           (rst),
    .adv_i         (adv_i),
    .flush_i       (flush_i),
    .add_rdy_i     (add_rdy_i),
    .mul_rdy_i     (mul_rdy_i),
    .src_sel_o     (src_sel),
    .s1_load_o     (s1_load),
    .out_load_o    (out_load),
    .out_clr_o     (out_clr),
    .arith_valid_o (arith_valid_o)
  );

  // stage 1
  fpu_rnd_align fpu_rnd_align_i (
    .clk       (clk),
    .src_sel_i (src_sel),
    .rmode_i   (rmode_i),
    .add_src_i (add_src_i),
    .mul_src_i (mul_src_i),
    .s1_load_i (s1_load),
    .aligned_o (aligned)
  );

  // stage 2, round then pack
  fpu_rnd_round fpu_rnd_round_i (
    .aligned_i (aligned),
    .rmode_i   (rmode_i),
    .rounded_o (rounded)
  );

  fpu_rnd_pack fpu_rnd_pack_i (
    .clk        (clk),
    .rst        (rst),
    .aligned_i  (aligned),
    .rounded_i  (rounded),
    .out_load_i (out_load),
    .out_clr_i  (out_clr),
    .result_o   (result_o),
    .flags_o    (flags_o)
  );

endmodule

// File: tb_fpu_rnd.sv
`timescale 1ns/1ns

module tb_fpu_rnd;
  import fpu_rnd_pkg::*;

  localparam int MAX_VEC = 64;

  // one line of the pattern file
  typedef struct packed {
    logic [3:0] grp;                          // test number
    logic [1:0] src;                          // 1 add, 2 mul
    logic [1:0] rm;
    logic       sign;
    logic       sub0;
    shamt_t     shr;
    shamt_t     shl;
    exp10_t     exp_shr;
    exp10_t     exp_shl;
    exp10_t     exp_sh0;
    fract28_t   fract28;
    logic [4:0] fl5;                          // {inv, inf, snan, qnan, anan_sign}
    word_t      res;
    fpu_flags_t flags;
  } pattern_t;

  logic       clk;
  logic       rst;
  logic       adv_i;
  logic       flush_i;
  rnd_mode_e  rmode_i;
  logic       add_rdy_i;
  logic       mul_rdy_i;
  add_src_t   add_src_i;
  mul_src_t   mul_src_i;
  word_t      result_o;
  logic       arith_valid_o;
  fpu_flags_t flags_o;

  pattern_t    pats [MAX_VEC];
  int          n_vec;
  int          err_cnt;
  int          chk_cnt;
  int          stall_cnt;
  int          cycles;
  int          cycle_limit;                   // 0 until patterns are read
  logic [31:0] lfsr;

  fpu_rnd_top fpu_rnd_top_i (
    .clk           (clk),
    .rst           (rst),
    .adv_i         (adv_i),
    .flush_i       (flush_i),
    .rmode_i       (rmode_i),
    .add_rdy_i     (add_rdy_i),
    .mul_rdy_i     (mul_rdy_i),
    .add_src_i     (add_src_i),
    .mul_src_i     (mul_src_i),
    .result_o      (result_o),
    .arith_valid_o (arith_valid_o),
    .flags_o       (flags_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                   // 20 ns period
  end

  // hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic bit take_bit();
    lfsr = lfsr_step(lfsr);                   // one step per bit
    return lfsr[0];
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1:       return "add nearest-even";
      2:       return "mul rounding modes";
      3:       return "mul denormal and zero";
      4:       return "special inputs";
      5:       return "random stalls";
      default: return "flush";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic read_patterns(output bit ok);
    int          fd;
    int          cnt;
    int          grp_v;
    int          src_v;
    int          rm_v;
    logic [31:0] h [11];
    string       line;
    ok    = 1'b1;
    n_vec = 0;
    fd    = $fopen("fpu_rnd_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file fpu_rnd_patterns.txt");
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != 8'h23) begin   // skip # lines
          cnt = $sscanf(line, "%d %d %d %h %h %h %h %h %h %h %h %h %h %h",
                        grp_v, src_v, rm_v, h[0], h[1], h[2], h[3], h[4], h[5],
                        h[6], h[7], h[8], h[9], h[10]);
          if (cnt != 14 || n_vec >= MAX_VEC) begin
            $display("pattern line could not be read: %s", line);
            ok = 1'b0;
          end else begin
            pats[n_vec] = {grp_v[3:0], src_v[1:0], rm_v[1:0], h[0][0], h[1][0],
                           h[2][4:0], h[3][4:0], h[4][9:0], h[5][9:0], h[6][9:0],
                           h[7][27:0], h[8][4:0], h[9], h[10][7:0]};
            n_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // put one source word on the bus, ready raised
  task automatic drive_item(input pattern_t p);
    add_src_i = '0;
    mul_src_i = '0;
    rmode_i   = rnd_mode_e'(p.rm);
    if (p.src == 2'd1) begin
      add_src_i.sign     = p.sign;
      add_src_i.sub_0    = p.sub0;
      add_src_i.shl      = p.shl;
      add_src_i.exp10shl = p.exp_shl;
      add_src_i.exp10sh0 = p.exp_sh0;
      add_src_i.fract28  = p.fract28;
      {add_src_i.inv, add_src_i.inf, add_src_i.snan, add_src_i.qnan,
       add_src_i.anan_sign} = p.fl5;
      add_rdy_i = 1'b1;
    end else begin
      mul_src_i.sign     = p.sign;
      mul_src_i.shr      = p.shr;
      mul_src_i.exp10shr = p.exp_shr;
      mul_src_i.shl      = p.shl[0];
      mul_src_i.exp10shl = p.exp_shl;
      mul_src_i.exp10sh0 = p.exp_sh0;
      mul_src_i.fract28  = p.fract28;
      {mul_src_i.inv, mul_src_i.inf, mul_src_i.snan, mul_src_i.qnan,
       mul_src_i.anan_sign} = p.fl5;
      mul_rdy_i = 1'b1;
    end
  endtask

  // called and left just after a falling edge
  task automatic run_item(input int i, input bit stalls);
    int         adv_edges;
    word_t      res_hold;
    fpu_flags_t flags_hold;
    logic       valid_hold;
    adv_edges = 0;
    drive_item(pats[i]);
    while (adv_edges < 2) begin
      adv_i      = stalls ? take_bit() : 1'b1;
      res_hold   = result_o;
      flags_hold = flags_o;
      valid_hold = arith_valid_o;
      @(posedge clk);
      @(negedge clk);
      if (adv_i) begin
        adv_edges++;
        if (adv_edges == 1) begin
          add_rdy_i = 1'b0;                   // source consumed
          mul_rdy_i = 1'b0;
          check_value($sformatf("vector %0d early arith_valid_o", i), arith_valid_o, 0);
        end
      end else begin
        stall_cnt++;                          // outputs must not move
        check_value($sformatf("vector %0d result_o in stall", i), result_o, res_hold);
        check_value($sformatf("vector %0d flags_o in stall", i), flags_o, flags_hold);
        check_value($sformatf("vector %0d valid in stall", i), arith_valid_o, valid_hold);
      end
    end
    check_value($sformatf("vector %0d arith_valid_o", i), arith_valid_o, 1);
    check_value($sformatf("vector %0d result_o", i), result_o, pats[i].res);
    check_value($sformatf("vector %0d flags_o", i), flags_o, pats[i].flags);
  endtask

  task automatic flush_item(input int i);
    drive_item(pats[i]);
    adv_i = 1'b1;
    @(posedge clk);
    @(negedge clk);
    add_rdy_i = 1'b0;                         // item now in stage 1
    mul_rdy_i = 1'b0;
    flush_i   = 1'b1;
    @(posedge clk);
    @(negedge clk);
    flush_i = 1'b0;
    check_value($sformatf("vector %0d valid after flush", i), arith_valid_o, 0);
    check_value($sformatf("vector %0d result after flush", i), result_o, pats[i].res);
    check_value($sformatf("vector %0d flags after flush", i), flags_o, pats[i].flags);
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      check_value($sformatf("vector %0d flushed item", i), arith_valid_o, 0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    bit ok;
    int n;
    int err0;
    rst       = 1'b1;
    adv_i     = 1'b0;
    flush_i   = 1'b0;
    rmode_i   = RM_NEAREST;
    add_rdy_i = 1'b0;
    mul_rdy_i = 1'b0;
    add_src_i = '0;
    mul_src_i = '0;
    err_cnt   = 0;
    chk_cnt   = 0;
    stall_cnt = 0;
    lfsr      = 32'h1d5029cc;
    read_patterns(ok);
    if (!ok) begin
      $display("tests failed");
      $finish;
    end else begin
      cycle_limit = 4 * n_vec + 200;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_value("result_o after reset", result_o, 0);
      check_value("flags_o after reset", flags_o, 0);
      check_value("arith_valid_o after reset", arith_valid_o, 0);
      for (int t = 1; t <= 6; t++) begin
        n    = 0;
        err0 = err_cnt;
        for (int i = 0; i < n_vec; i++) begin
          if (pats[i].grp == t) begin
            if (t == 6) flush_item(i);
            else run_item(i, t == 5);
            n++;
          end
        end
        if (n == 0) begin
          $display("test %0d has no vectors in the pattern file", t);
          err_cnt++;
        end
        $display("test %0d %s: %0d vectors, %0d errors, %0d stall cycles so far",
                 t, test_name(t), n, err_cnt - err0, stall_cnt);
      end
      $display("%0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
      $finish;
    end
  end

endmodule
